// ==== all.f ====
+incdir+tests
hdl/c1tx_pkg.sv
hdl/c1tx_req_intake.sv
hdl/c1tx_line_buffer.sv
hdl/c1tx_packet_drain.sv
hdl/c1tx_shim.sv
tests/tb_c1tx_shim.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write-request shim testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f all.f \
    --top-module tb_c1tx_shim \
    -Mdir obj_dir

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/Vtb_c1tx_shim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== tests/tb_c1tx_table.svh ====
// Stimulus table for the write-request shim testbench
// Packet rows each describe one request, phase rows pick a run of packet rows
// and say how host and accelerator behave and which flags to expect
// Included inside the testbench module after the package import

`ifndef TB_C1TX_TABLE_SVH
`define TB_C1TX_TABLE_SVH

// Host almost-full behavior during a phase
localparam logic [1:0] HOST_OPEN  = 2'd0;
localparam logic [1:0] HOST_HOLD  = 2'd1;
localparam logic [1:0] HOST_RAISE = 2'd2;

typedef struct packed
{
    logic [REQ_TYPE_WIDTH-1:0] req_type;
    logic [CL_LEN_WIDTH-1:0]   cl_len;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [TAG_WIDTH-1:0]      tag;
    // Upper half of every data beat
    logic [31:0]               seed;
} pkt_row_t;

typedef struct packed
{
    logic [7:0] first_pkt;
    logic [7:0] num_pkt;
    logic [7:0] repeats;
    logic [1:0] host_mode;
    // Accelerator stops starting packets on almost-full
    logic       obey_af;
    // Beats that survive in the buffer, later ones are dropped
    logic [7:0] keep_max;
    logic       exp_af_mid;
    logic       exp_err;
    // Responses returned before the last flag check
    logic [7:0] rsp_count;
    logic       exp_af_end;
} phase_row_t;

localparam int NUM_PKTS   = 8;
localparam int NUM_PHASES = 7;

// Columns: type, line-count code, address, tag, data seed
localparam pkt_row_t PKT_ROWS [NUM_PKTS] = '{
    '{REQ_WRLINE_I, 2'd0, 16'h0100, 8'h01, 32'ha000_0001},
    '{REQ_WRLINE_M, 2'd1, 16'h0200, 8'h02, 32'ha000_0002},
    '{REQ_WRFENCE,  2'd0, 16'h0000, 8'h03, 32'ha000_0003},
    '{REQ_WRLINE_I, 2'd3, 16'h0300, 8'h04, 32'ha000_0004},
    '{REQ_WRLINE_M, 2'd0, 16'h0400, 8'h05, 32'ha000_0005},
    '{REQ_WRLINE_I, 2'd3, 16'h0500, 8'h06, 32'hb000_0006},
    '{REQ_WRLINE_M, 2'd0, 16'h0600, 8'h07, 32'hb000_0007},
    '{REQ_WRLINE_I, 2'd0, 16'h0700, 8'h08, 32'hc000_0008}
};

// Columns: first, count, repeats, host, obey, keep, af mid, error, responses, af end
localparam phase_row_t PHASES [NUM_PHASES] = '{
    // Mixed ordering, once and then twice over
    '{8'd0, 8'd5, 8'd1,  HOST_OPEN,  1'b1, 8'd255, 1'b0, 1'b0, 8'd0, 1'b0},
    '{8'd0, 8'd5, 8'd2,  HOST_OPEN,  1'b1, 8'd255, 1'b0, 1'b0, 8'd0, 1'b0},
    // Host goes almost-full inside a four-line write
    '{8'd5, 8'd2, 8'd1,  HOST_RAISE, 1'b1, 8'd255, 1'b0, 1'b0, 8'd0, 1'b0},
    // Buffer level almost-full
    '{8'd7, 8'd1, 8'd16, HOST_HOLD,  1'b1, 8'd255, 1'b1, 1'b0, 8'd0, 1'b0},
    // Credit almost-full, three responses bring it to the limit
    '{8'd7, 8'd1, 8'd23, HOST_OPEN,  1'b0, 8'd255, 1'b1, 1'b0, 8'd3, 1'b0},
    // Overflow, only the first 16 beats fit
    '{8'd7, 8'd1, 8'd20, HOST_HOLD,  1'b0, 8'd16,  1'b1, 1'b1, 8'd0, 1'b1},
    // Traffic after the error
    '{8'd0, 8'd5, 8'd1,  HOST_OPEN,  1'b0, 8'd255, 1'b1, 1'b1, 8'd0, 1'b1}
};

`endif

// ==== tests/tb_c1tx_shim.sv ====
// Testbench for the write-request shim
// Applies the phase table, keeps a queue of accepted beats and compares every
// host beat against it, and checks the almost-full and error flags per phase
// A watchdog bounds the run

`timescale 1ns/10ps

module tb_c1tx_shim;

    import c1tx_pkg::*;

    `include "tb_c1tx_table.svh"

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int SETTLE_CYCLES   = 8;
    localparam int HOLD_CYCLES     = 16;
    localparam int WATCHDOG_CYCLES = NUM_PHASES * 200 + 1000;

    logic                  afu_clk;
    logic                  reset;
    logic                  afu_tx_valid;
    c1_hdr_t               afu_tx_hdr;
    logic [DATA_WIDTH-1:0] afu_tx_data;
    logic                  afu_tx_almfull;
    logic                  afu_error;
    logic                  fiu_tx_valid;
    c1_hdr_t               fiu_tx_hdr;
    logic [DATA_WIDTH-1:0] fiu_tx_data;
    logic                  fiu_tx_almfull;
    logic                  fiu_rsp_valid;

    // Scoreboard and host model state
    c1_hdr_t               exp_hdr_q [$];
    logic [DATA_WIDTH-1:0] exp_data_q [$];
    int                    outstanding = 0;
    int                    tb_rem = 0;
    int                    multi_sop_count = 0;
    int                    sop_mark = 0;
    logic                  af_last = 1'b0;
    logic [1:0]            host_mode = HOST_OPEN;

    c1tx_shim u_dut
    (
        .afu_clk        (afu_clk),
        .reset          (reset),
        .afu_tx_valid   (afu_tx_valid),
        .afu_tx_hdr     (afu_tx_hdr),
        .afu_tx_data    (afu_tx_data),
        .afu_tx_almfull (afu_tx_almfull),
        .afu_error      (afu_error),
        .fiu_tx_valid   (fiu_tx_valid),
        .fiu_tx_hdr     (fiu_tx_hdr),
        .fiu_tx_data    (fiu_tx_data),
        .fiu_tx_almfull (fiu_tx_almfull),
        .fiu_rsp_valid  (fiu_rsp_valid)
    );

    initial
    begin
        afu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) afu_clk = ~afu_clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("error at time %0t: %s", $time, msg));
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the run did not finish within the watchdog limit");
    end

    // Inputs change 1 ns after the edge
    task automatic step_cycle();
        @(posedge afu_clk);
        #1;
        // Host answers the first multi-line header with almost-full
        if (host_mode == HOST_RAISE && multi_sop_count > sop_mark)
        begin
            fiu_tx_almfull = 1'b1;
        end
    endtask

    task automatic settle(input int n);
        repeat (n) step_cycle();
    endtask

    function automatic c1_hdr_t make_hdr(input pkt_row_t pkt, input int rep, input logic sop);
        c1_hdr_t h;
        h = '0;
        if (pkt.req_type == REQ_WRFENCE)
        begin
            h.fence.req_type = pkt.req_type;
            h.fence.tag      = pkt.tag + TAG_WIDTH'(rep);
        end
        else
        begin
            h.wr.req_type = pkt.req_type;
            h.wr.tag      = pkt.tag + TAG_WIDTH'(rep);
            h.wr.cl_len   = pkt.cl_len;
            h.wr.sop      = sop;
            h.wr.addr     = pkt.addr + ADDR_WIDTH'(rep);
        end
        return h;
    endfunction

    // Seed, repeat and beat index make every beat distinct
    function automatic logic [DATA_WIDTH-1:0] make_data(input pkt_row_t pkt, input int rep,
                                                        input int beat);
        return {pkt.seed, 16'(rep), 16'(beat)};
    endfunction

    task automatic drive_beat(input c1_hdr_t hdr, input logic [DATA_WIDTH-1:0] data,
                              input logic keep);
        afu_tx_valid = 1'b1;
        afu_tx_hdr   = hdr;
        afu_tx_data  = data;
        // Every presented beat takes a credit, dropped or not
        outstanding  = outstanding + 1;
        if (keep)
        begin
            exp_hdr_q.push_back(hdr);
            exp_data_q.push_back(data);
        end
    endtask

    task automatic return_credits(input int n);
        repeat (n)
        begin
            step_cycle();
            fiu_rsp_valid = 1'b1;
            outstanding   = outstanding - 1;
            step_cycle();
            fiu_rsp_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (exp_hdr_q.size() != 0) step_cycle();
    endtask

    task automatic check_flags(input logic exp_af, input logic exp_err, input string when_txt);
        assert (afu_tx_almfull === exp_af)
        else report_mismatch($sformatf("afu_tx_almfull is %b, expected %b %s",
                                       afu_tx_almfull, exp_af, when_txt));
        assert (afu_error === exp_err)
        else report_mismatch($sformatf("afu_error is %b, expected %b %s",
                                       afu_error, exp_err, when_txt));
    endtask

    task automatic run_phase(input phase_row_t ph, input int idx);
        int       sent;
        logic     stop;
        pkt_row_t pkt;
        sent           = 0;
        stop           = 1'b0;
        sop_mark       = multi_sop_count;
        host_mode      = ph.host_mode;
        fiu_tx_almfull = (ph.host_mode == HOST_HOLD);
        for (int r = 0; r < int'(ph.repeats); r++)
        begin
            for (int k = 0; k < int'(ph.num_pkt); k++)
            begin
                pkt = PKT_ROWS[int'(ph.first_pkt) + k];
                step_cycle();
                // A well behaved accelerator starts no packet on almost-full
                if (ph.obey_af && afu_tx_almfull)
                begin
                    stop = 1'b1;
                end
                if (stop)
                begin
                    afu_tx_valid = 1'b0;
                end
                else
                begin
                    for (int b = 0; b <= int'(pkt.cl_len); b++)
                    begin
                        if (b > 0)
                        begin
                            step_cycle();
                        end
                        drive_beat(make_hdr(pkt, r, b == 0), make_data(pkt, r, b),
                                   sent < int'(ph.keep_max));
                        sent = sent + 1;
                    end
                end
            end
        end
        step_cycle();
        afu_tx_valid = 1'b0;
        settle(SETTLE_CYCLES);
        if (ph.host_mode == HOST_HOLD)
        begin
            check_flags(ph.exp_af_mid, ph.exp_err, $sformatf("in phase %0d with host held", idx));
            if (ph.obey_af)
            begin
                assert (sent < BUF_DEPTH)
                else abort_run("the accelerator filled the buffer before almost-full rose");
            end
            fiu_tx_almfull = 1'b0;
        end
        else if (ph.host_mode == HOST_RAISE)
        begin
            // All beats of the open packet must still come out
            while (!(multi_sop_count > sop_mark && tb_rem == 0)) step_cycle();
            settle(HOLD_CYCLES);
            assert (exp_hdr_q.size() > 0)
            else abort_run("a later packet drained while the host was almost-full");
            host_mode      = HOST_OPEN;
            fiu_tx_almfull = 1'b0;
        end
        wait_drained();
        settle(SETTLE_CYCLES);
        if (ph.host_mode != HOST_HOLD)
        begin
            check_flags(ph.exp_af_mid, ph.exp_err, $sformatf("in phase %0d after drain", idx));
        end
        return_credits(int'(ph.rsp_count));
        settle(SETTLE_CYCLES);
        check_flags(ph.exp_af_end, ph.exp_err, $sformatf("in phase %0d after responses", idx));
        // Clear the rest so the next phase starts with no credits out
        return_credits(outstanding);
        settle(SETTLE_CYCLES);
    endtask

    // Host side monitor, sampled away from the driving edge
    always @(negedge afu_clk)
    begin
        c1_hdr_t               want_hdr;
        logic [DATA_WIDTH-1:0] want_data;
        if (!reset && fiu_tx_valid)
        begin
            assert (exp_hdr_q.size() > 0)
            else abort_run("the host port sent a beat that was never accepted");
            want_hdr  = exp_hdr_q.pop_front();
            want_data = exp_data_q.pop_front();
            assert (fiu_tx_hdr === want_hdr)
            else report_mismatch($sformatf("host header %h, expected %h", fiu_tx_hdr, want_hdr));
            assert (fiu_tx_data === want_data)
            else report_mismatch($sformatf("host data %h, expected %h", fiu_tx_data, want_data));
            if (tb_rem > 0)
            begin
                tb_rem = tb_rem - 1;
            end
            else
            begin
                // The pop behind this beat saw the previous cycle's level
                assert (!af_last)
                else abort_run("a new packet started while the host was almost-full");
                if (fiu_tx_hdr.wr.req_type inside {REQ_WRLINE_I, REQ_WRLINE_M} &&
                    fiu_tx_hdr.wr.sop && fiu_tx_hdr.wr.cl_len != '0)
                begin
                    tb_rem          = int'(fiu_tx_hdr.wr.cl_len);
                    multi_sop_count = multi_sop_count + 1;
                end
            end
        end
        af_last = fiu_tx_almfull;
    end

    initial
    begin
        int gap;
        // Fixed seed, only the gaps between rows are random
        void'($urandom(32'h7224));
        reset          = 1'b1;
        afu_tx_valid   = 1'b0;
        afu_tx_hdr     = '0;
        afu_tx_data    = '0;
        fiu_tx_almfull = 1'b0;
        fiu_rsp_valid  = 1'b0;
        repeat (RESET_CYCLES) @(posedge afu_clk);
        #1;
        reset = 1'b0;
        settle(2);
        check_flags(1'b0, 1'b0, "after reset");
        for (int p = 0; p < NUM_PHASES; p++)
        begin
            run_phase(PHASES[p], p);
            gap = 1 + int'($urandom % 8);
            settle(gap);
        end
        assert (outstanding == 0 && exp_hdr_q.size() == 0)
        else abort_run("traffic was left over at the end of the run");
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== hdl/c1tx_shim.sv ====
// Top level of the write-request shim between accelerator and host link
// Intake registers accelerator beats into the line buffer,
// the drain pops them toward the host without splitting packets
// Everything runs on afu_clk with a synchronous active-high reset

`timescale 1ns/10ps

module c1tx_shim
(
    input  logic                             afu_clk,
    input  logic                             reset,

    // Accelerator side
    input  logic                             afu_tx_valid,
    input  c1tx_pkg::c1_hdr_t                afu_tx_hdr,
    input  logic [c1tx_pkg::DATA_WIDTH-1:0]  afu_tx_data,
    output logic                             afu_tx_almfull,
    output logic                             afu_error,

    // Host side
    output logic                             fiu_tx_valid,
    output c1tx_pkg::c1_hdr_t                fiu_tx_hdr,
    output logic [c1tx_pkg::DATA_WIDTH-1:0]  fiu_tx_data,
    input  logic                             fiu_tx_almfull,
    input  logic                             fiu_rsp_valid
);

    import c1tx_pkg::*;

    // Intake to buffer
    logic                  buf_wr_en;
    c1_hdr_t               buf_wr_hdr;
    logic [DATA_WIDTH-1:0] buf_wr_data;
    logic                  buf_full;
    logic                  buf_almfull;

    // Buffer to drain
    logic                  buf_rd_en;
    logic                  buf_empty;
    c1_hdr_t               buf_rd_hdr;
    logic [DATA_WIDTH-1:0] buf_rd_data;

    c1tx_req_intake u_intake
    (
        .afu_clk        (afu_clk),
        .reset          (reset),
        .afu_tx_valid   (afu_tx_valid),
        .afu_tx_hdr     (afu_tx_hdr),
        .afu_tx_data    (afu_tx_data),
        .fiu_rsp_valid  (fiu_rsp_valid),
        .buf_full       (buf_full),
        .buf_almfull    (buf_almfull),
        .buf_wr_en      (buf_wr_en),
        .buf_wr_hdr     (buf_wr_hdr),
        .buf_wr_data    (buf_wr_data),
        .afu_tx_almfull (afu_tx_almfull),
        .afu_error      (afu_error)
    );

    c1tx_line_buffer u_buffer
    (
        .afu_clk     (afu_clk),
        .reset       (reset),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_hdr  (buf_wr_hdr),
        .buf_wr_data (buf_wr_data),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_hdr  (buf_rd_hdr),
        .buf_rd_data (buf_rd_data),
        .buf_empty   (buf_empty),
        .buf_full    (buf_full),
        .buf_almfull (buf_almfull)
    );

    c1tx_packet_drain u_drain
    (
        .afu_clk        (afu_clk),
        .reset          (reset),
        .buf_empty      (buf_empty),
        .buf_rd_hdr     (buf_rd_hdr),
        .buf_rd_data    (buf_rd_data),
        .buf_rd_en      (buf_rd_en),
        .fiu_tx_almfull (fiu_tx_almfull),
        .fiu_tx_valid   (fiu_tx_valid),
        .fiu_tx_hdr     (fiu_tx_hdr),
        .fiu_tx_data    (fiu_tx_data)
    );

endmodule

// ==== hdl/c1tx_packet_drain.sv ====
// Host side of the write-request shim
// Pops the line buffer toward the host link and registers each popped entry
// Host almost-full stops new packets, but a multi-line write already
// started is always finished so the link never sees half a packet

`timescale 1ns/10ps

module c1tx_packet_drain
(
    input  logic                             afu_clk,
    input  logic                             reset,

    // Line buffer read side
    input  logic                             buf_empty,
    input  c1tx_pkg::c1_hdr_t                buf_rd_hdr,
    input  logic [c1tx_pkg::DATA_WIDTH-1:0]  buf_rd_data,
    output logic                             buf_rd_en,

    // Host link
    input  logic                             fiu_tx_almfull,
    output logic                             fiu_tx_valid,
    output c1tx_pkg::c1_hdr_t                fiu_tx_hdr,
    output logic [c1tx_pkg::DATA_WIDTH-1:0]  fiu_tx_data
);

    import c1tx_pkg::*;

    logic                    in_packet;
    logic [CL_LEN_WIDTH-1:0] rem_beats;
    logic                    complete_partial;
    logic                    starts_packet;

    // Force the rest of a packet out, but only when the previous cycle
    // did not already pop, which keeps pops from running past the last beat
    assign complete_partial = in_packet && !fiu_tx_valid;

    assign buf_rd_en = !buf_empty && (!fiu_tx_almfull || complete_partial);

    // Sent beat valid follows the pop by one cycle
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            fiu_tx_valid <= 1'b0;
        end
        else
        begin
            fiu_tx_valid <= buf_rd_en;
        end
    end

    // Sent beat payload
    always_ff @(posedge afu_clk)
    begin
        if (buf_rd_en)
        begin
            fiu_tx_hdr  <= buf_rd_hdr;
            fiu_tx_data <= buf_rd_data;
        end
    end

    // Decode the sent header
    // Only a write with sop and more than one line opens a packet
    always_comb
    begin
        case (fiu_tx_hdr.fence.req_type)
            REQ_WRLINE_I,
            REQ_WRLINE_M:
                starts_packet = fiu_tx_hdr.wr.sop && (fiu_tx_hdr.wr.cl_len != '0);
            REQ_WRFENCE:
                starts_packet = 1'b0;
            default:
                starts_packet = 1'b0;
        endcase
    end

    // Packet tracking on each sent beat
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            in_packet <= 1'b0;
            rem_beats <= '0;
        end
        else if (fiu_tx_valid)
        begin
            if (in_packet)
            begin
                // Last beat when one remains
                in_packet <= (rem_beats != CL_LEN_WIDTH'(1));
                rem_beats <= rem_beats - 1'b1;
            end
            else
            begin
                in_packet <= starts_packet;
                // Code is lines minus one, which is the beats still to come
                rem_beats <= fiu_tx_hdr.wr.cl_len;
            end
        end
    end

endmodule

// ==== hdl/c1tx_line_buffer.sv ====
// Single-clock FIFO holding header plus data beats of the write channel
// Head entry is presented show-ahead, a read pops it on the next edge
// Flags come from the occupancy count left by the last edge
// Almost-full rises while BUF_ALMFULL_FREE or fewer entries are free

`timescale 1ns/10ps

module c1tx_line_buffer
(
    input  logic                             afu_clk,
    input  logic                             reset,

    // Write side
    input  logic                             buf_wr_en,
    input  c1tx_pkg::c1_hdr_t                buf_wr_hdr,
    input  logic [c1tx_pkg::DATA_WIDTH-1:0]  buf_wr_data,

    // Read side
    input  logic                             buf_rd_en,
    output c1tx_pkg::c1_hdr_t                buf_rd_hdr,
    output logic [c1tx_pkg::DATA_WIDTH-1:0]  buf_rd_data,

    // Status
    output logic                             buf_empty,
    output logic                             buf_full,
    output logic                             buf_almfull
);

    import c1tx_pkg::*;

    c1_hdr_t                  hdr_mem  [BUF_DEPTH];
    logic [DATA_WIDTH-1:0]    data_mem [BUF_DEPTH];
    logic [BUF_DEPTH_RADIX-1:0] wr_ptr;
    logic [BUF_DEPTH_RADIX-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from an empty one
    logic [BUF_DEPTH_RADIX:0] count;
    logic                     do_wr;
    logic                     do_rd;

    // A write into a full buffer only lands when a read frees a slot
    assign do_wr = buf_wr_en && (!buf_full || buf_rd_en);
    assign do_rd = buf_rd_en && !buf_empty;

    // Storage
    always_ff @(posedge afu_clk)
    begin
        if (do_wr)
        begin
            hdr_mem[wr_ptr]  <= buf_wr_hdr;
            data_mem[wr_ptr] <= buf_wr_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_wr && !do_rd)
            begin
                count <= count + 1'b1;
            end
            else if (!do_wr && do_rd)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Show-ahead head entry
    assign buf_rd_hdr  = hdr_mem[rd_ptr];
    assign buf_rd_data = data_mem[rd_ptr];

    assign buf_empty   = (count == '0);
    assign buf_full    = (count == (BUF_DEPTH_RADIX+1)'(BUF_DEPTH));
    assign buf_almfull = (count >= (BUF_DEPTH_RADIX+1)'(BUF_DEPTH - BUF_ALMFULL_FREE));

    // The drain never pops an empty buffer
    a_no_read_empty : assert property (
        @(posedge afu_clk) disable iff (reset)
        buf_rd_en |-> !buf_empty
    );

    // The intake never pushes into a full buffer unless a pop makes room
    a_no_write_full : assert property (
        @(posedge afu_clk) disable iff (reset)
        (buf_wr_en && buf_full) |-> buf_rd_en
    );

endmodule

// ==== hdl/c1tx_req_intake.sv ====
// Accelerator side of the write-request shim
// Registers each incoming beat and pushes it into the line buffer
// A beat that meets a full buffer is dropped and latches a sticky error
// Also tracks outstanding write credits and forms almost-full toward the accelerator

`timescale 1ns/10ps

module c1tx_req_intake
(
    input  logic                             afu_clk,
    input  logic                             reset,

    // Accelerator beats
    input  logic                             afu_tx_valid,
    input  c1tx_pkg::c1_hdr_t                afu_tx_hdr,
    input  logic [c1tx_pkg::DATA_WIDTH-1:0]  afu_tx_data,

    // One pulse per returned write credit
    input  logic                             fiu_rsp_valid,

    // Line buffer write side
    input  logic                             buf_full,
    input  logic                             buf_almfull,
    output logic                             buf_wr_en,
    output c1tx_pkg::c1_hdr_t                buf_wr_hdr,
    output logic [c1tx_pkg::DATA_WIDTH-1:0]  buf_wr_data,

    // Status toward the accelerator
    output logic                             afu_tx_almfull,
    output logic                             afu_error
);

    import c1tx_pkg::*;

    logic                    afu_q_valid;
    c1_hdr_t                 afu_q_hdr;
    logic [DATA_WIDTH-1:0]   afu_q_data;
    logic [CREDIT_RADIX-1:0] credit_cnt;

    // Input stage valid
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            afu_q_valid <= 1'b0;
        end
        else
        begin
            afu_q_valid <= afu_tx_valid;
        end
    end

    // Input stage payload
    always_ff @(posedge afu_clk)
    begin
        afu_q_hdr  <= afu_tx_hdr;
        afu_q_data <= afu_tx_data;
    end

    // Push on the next edge unless the buffer has no room
    assign buf_wr_en   = afu_q_valid && !buf_full;
    assign buf_wr_hdr  = afu_q_hdr;
    assign buf_wr_data = afu_q_data;

    // Credits go up per registered beat, down per response pulse
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            credit_cnt <= '0;
        end
        else if (afu_q_valid && !fiu_rsp_valid)
        begin
            credit_cnt <= credit_cnt + 1'b1;
        end
        else if (!afu_q_valid && fiu_rsp_valid)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    // Sticky overflow error and registered almost-full
    always_ff @(posedge afu_clk)
    begin
        if (reset)
        begin
            afu_error      <= 1'b0;
            afu_tx_almfull <= 1'b0;
        end
        else
        begin
            // Stays set because a dropped beat is never recovered
            afu_error      <= afu_error || (afu_q_valid && buf_full);
            // Any cause holds off new packets
            afu_tx_almfull <= buf_almfull ||
                              (credit_cnt > CREDIT_RADIX'(CREDIT_LIMIT)) ||
                              afu_error;
        end
    end

    // A response with nothing outstanding would wrap the counter
    a_credit_no_underflow : assert property (
        @(posedge afu_clk) disable iff (reset)
        ((credit_cnt == '0) && fiu_rsp_valid) |-> afu_q_valid
    );

    // A beat on a saturated counter needs a response in the same cycle
    a_credit_no_overflow : assert property (
        @(posedge afu_clk) disable iff (reset)
        ((credit_cnt == '1) && afu_q_valid) |-> fiu_rsp_valid
    );

endmodule

// ==== hdl/c1tx_pkg.sv ====
// Shared definitions for the write-request shim between accelerator and host link
// Holds the beat widths, the buffer and credit sizing and the request-type codes
// The header word is a packed union read either as a write or as a fence
// Modules import it by wildcard in their bodies and use scoped names in port lists

package c1tx_pkg;

    // Payload and header field widths
    localparam int DATA_WIDTH     = 64;
    localparam int ADDR_WIDTH     = 16;
    localparam int TAG_WIDTH      = 8;
    // Line count is coded as lines minus one, so 0, 1 and 3 are legal
    localparam int CL_LEN_WIDTH   = 2;
    localparam int REQ_TYPE_WIDTH = 2;

    // Request type codes
    localparam logic [REQ_TYPE_WIDTH-1:0] REQ_WRLINE_I = 2'd0;
    localparam logic [REQ_TYPE_WIDTH-1:0] REQ_WRLINE_M = 2'd1;
    localparam logic [REQ_TYPE_WIDTH-1:0] REQ_WRFENCE  = 2'd2;

    // Header word is the sum of the write view fields
    // Type, tag, line count, sop and address
    localparam int HDR_WIDTH = REQ_TYPE_WIDTH + TAG_WIDTH + CL_LEN_WIDTH + 1 + ADDR_WIDTH;

    // Bits left over in the fence view
    localparam int FENCE_RSVD_WIDTH = HDR_WIDTH - REQ_TYPE_WIDTH - TAG_WIDTH;

    // Line buffer sizing
    localparam int BUF_DEPTH_RADIX  = 4;
    localparam int BUF_DEPTH        = 2 ** BUF_DEPTH_RADIX;
    // Almost-full once this many free entries or fewer remain
    // Leaves room for beats already in flight toward the buffer
    localparam int BUF_ALMFULL_FREE = 6;

    // Outstanding write credits
    localparam int CREDIT_RADIX = 5;
    localparam int CREDIT_LIMIT = 20;

    // Write view of the header
    typedef struct packed
    {
        logic [REQ_TYPE_WIDTH-1:0] req_type;
        logic [TAG_WIDTH-1:0]      tag;
        logic [CL_LEN_WIDTH-1:0]   cl_len;
        // Set only on the first beat of a packet
        logic                      sop;
        logic [ADDR_WIDTH-1:0]     addr;
    } c1_wr_hdr_t;

    // Fence view of the header
    typedef struct packed
    {
        logic [REQ_TYPE_WIDTH-1:0]   req_type;
        logic [TAG_WIDTH-1:0]        tag;
        logic [FENCE_RSVD_WIDTH-1:0] rsvd;
    } c1_fence_hdr_t;

    // One header word, two decodes
    // The request type sits in the top bits of both views
    typedef union packed
    {
        c1_wr_hdr_t    wr;
        c1_fence_hdr_t fence;
    } c1_hdr_t;

endpackage
